//--- axi_mem_uart.f
design/axi_mem_pkg.sv
design/stall_lfsr.sv
design/axi_read_engine.sv
design/axi_write_engine.sv
design/mem_bank.sv
design/axi_mem_uart.sv
test/tb_axi_mem_uart.sv

//--- design/axi_mem_pkg.sv
package axi_mem_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  // response codes on r and b channels
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // serial port byte address
  // writes here go to the character output, never to the array
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'ha00003f8;

endpackage

//--- design/axi_mem_uart.sv
`timescale 1ns/1ps

module axi_mem_uart
  import axi_mem_pkg::*;
#(
  parameter int          DEPTH_WORDS = 256,
  parameter bit          STALL_EN    = 1'b1,
  parameter logic [19:0] STALL_SEED  = 20'd101
) (
  input  logic              clk,
  input  logic              rst_i,
  // read address
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ID_W-1:0]   ar_id_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  // read data
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output logic [ID_W-1:0]   r_id_o,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  // write address
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  logic [ID_W-1:0]   aw_id_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  // write data
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  // write response
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output logic [ID_W-1:0]   b_id_o,
  output logic [1:0]        b_resp_o,
  // serial port
  output logic              uart_valid_o,
  output logic [7:0]        uart_data_o
);

  logic              go;
  logic              rd_req;
  logic [ADDR_W-4:0] rd_addr;
  logic              rd_grant;
  logic              rd_done;
  logic [DATA_W-1:0] rd_data;
  logic [1:0]        rd_resp;
  logic              wr_req;
  logic [ADDR_W-4:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;
  logic              wr_grant;
  logic              wr_done;
  logic [1:0]        wr_resp;

  stall_lfsr #(
    .STALL_EN  (STALL_EN),
    .STALL_SEED(STALL_SEED)
  ) stall_lfsr_i (
    .clk  (clk),
    .rst_i(rst_i),
    .go_o (go)
  );

  axi_read_engine axi_read_engine_i (
    .clk       (clk),
    .rst_i     (rst_i),
    .go_i      (go),
    .ar_valid_i(ar_valid_i),
    .ar_ready_o(ar_ready_o),
    .ar_id_i   (ar_id_i),
    .ar_addr_i (ar_addr_i),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i),
    .r_id_o    (r_id_o),
    .r_data_o  (r_data_o),
    .r_resp_o  (r_resp_o),
    .rd_req_o  (rd_req),
    .rd_addr_o (rd_addr),
    .rd_grant_i(rd_grant),
    .rd_done_i (rd_done),
    .rd_data_i (rd_data),
    .rd_resp_i (rd_resp)
  );

  axi_write_engine axi_write_engine_i (
    .clk       (clk),
    .rst_i     (rst_i),
    .go_i      (go),
    .aw_valid_i(aw_valid_i),
    .aw_ready_o(aw_ready_o),
    .aw_id_i   (aw_id_i),
    .aw_addr_i (aw_addr_i),
    .w_valid_i (w_valid_i),
    .w_ready_o (w_ready_o),
    .w_data_i  (w_data_i),
    .w_strb_i  (w_strb_i),
    .b_valid_o (b_valid_o),
    .b_ready_i (b_ready_i),
    .b_id_o    (b_id_o),
    .b_resp_o  (b_resp_o),
    .wr_req_o  (wr_req),
    .wr_addr_o (wr_addr),
    .wr_data_o (wr_data),
    .wr_strb_o (wr_strb),
    .wr_grant_i(wr_grant),
    .wr_done_i (wr_done),
    .wr_resp_i (wr_resp)
  );

  mem_bank #(
    .DEPTH_WORDS(DEPTH_WORDS)
  ) mem_bank_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .rd_req_i    (rd_req),
    .rd_addr_i   (rd_addr),
    .rd_grant_o  (rd_grant),
    .rd_done_o   (rd_done),
    .rd_data_o   (rd_data),
    .rd_resp_o   (rd_resp),
    .wr_req_i    (wr_req),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .wr_grant_o  (wr_grant),
    .wr_done_o   (wr_done),
    .wr_resp_o   (wr_resp),
    .uart_valid_o(uart_valid_o),
    .uart_data_o (uart_data_o)
  );

endmodule

//--- design/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine
  import axi_mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst_i,
  input  logic              go_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ID_W-1:0]   ar_id_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output logic [ID_W-1:0]   r_id_o,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  output logic              rd_req_o,
  output logic [ADDR_W-4:0] rd_addr_o,
  input  logic              rd_grant_i,
  input  logic              rd_done_i,
  input  logic [DATA_W-1:0] rd_data_i,
  input  logic [1:0]        rd_resp_i
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ  = 2'd1;
  localparam logic [1:0] S_RESP = 2'd2;

  logic [1:0]        state_q;
  logic              req_q;
  logic              pend_q;
  logic [ID_W-1:0]   id_q;
  logic [ADDR_W-4:0] addr_q;
  logic [DATA_W-1:0] data_q;
  logic [1:0]        resp_q;
  logic              ar_fire;

  assign ar_ready_o = (state_q == S_IDLE) && go_i && ar_valid_i;
  assign ar_fire    = ar_valid_i && ar_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      req_q   <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (ar_fire) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          // grant and done are pulses and ignore go
          if (rd_grant_i) begin
            req_q  <= 1'b0;
            pend_q <= 1'b1;
          end else if (go_i && !req_q && !pend_q) begin
            req_q <= 1'b1;
          end
          if (rd_done_i) begin
            pend_q  <= 1'b0;
            state_q <= S_RESP;
          end
        end
        S_RESP: begin
          if (r_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q   <= ar_id_i;
      addr_q <= ar_addr_i[ADDR_W-1:3];
    end
    // held unchanged through S_RESP
    if (rd_done_i && state_q == S_REQ) begin
      data_q <= rd_data_i;
      resp_q <= rd_resp_i;
    end
  end

  assign rd_req_o  = req_q;
  assign rd_addr_o = addr_q;
  assign r_valid_o = (state_q == S_RESP);
  assign r_id_o    = id_q;
  assign r_data_o  = data_q;
  assign r_resp_o  = resp_q;

endmodule

//--- design/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine
  import axi_mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst_i,
  input  logic              go_i,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  logic [ID_W-1:0]   aw_id_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output logic [ID_W-1:0]   b_id_o,
  output logic [1:0]        b_resp_o,
  output logic              wr_req_o,
  output logic [ADDR_W-4:0] wr_addr_o,
  output logic [DATA_W-1:0] wr_data_o,
  output logic [STRB_W-1:0] wr_strb_o,
  input  logic              wr_grant_i,
  input  logic              wr_done_i,
  input  logic [1:0]        wr_resp_i
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_DATA = 2'd1;
  localparam logic [1:0] S_REQ  = 2'd2;
  localparam logic [1:0] S_RESP = 2'd3;

  logic [1:0]        state_q;
  logic              req_q;
  logic              pend_q;
  logic [ID_W-1:0]   id_q;
  logic [ADDR_W-4:0] addr_q;
  logic [DATA_W-1:0] data_q;
  logic [STRB_W-1:0] strb_q;
  logic [1:0]        resp_q;
  logic              aw_fire;
  logic              w_fire;

  // aw and w sit in different states, so they never transfer together
  assign aw_ready_o = (state_q == S_IDLE) && go_i && aw_valid_i;
  assign w_ready_o  = (state_q == S_DATA) && go_i && w_valid_i;
  assign aw_fire    = aw_valid_i && aw_ready_o;
  assign w_fire     = w_valid_i && w_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      req_q   <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (aw_fire) begin
            state_q <= S_DATA;
          end
        end
        S_DATA: begin
          if (w_fire) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          if (wr_grant_i) begin
            req_q  <= 1'b0;
            pend_q <= 1'b1;
          end else if (go_i && !req_q && !pend_q) begin
            req_q <= 1'b1;
          end
          if (wr_done_i) begin
            pend_q  <= 1'b0;
            state_q <= S_RESP;
          end
        end
        S_RESP: begin
          // leaves on b_ready_i whatever go says
          if (b_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q   <= aw_id_i;
      addr_q <= aw_addr_i[ADDR_W-1:3];
    end
    if (w_fire) begin
      data_q <= w_data_i;
      strb_q <= w_strb_i;
    end
    if (wr_done_i && state_q == S_REQ) begin
      resp_q <= wr_resp_i;
    end
  end

  assign wr_req_o  = req_q;
  assign wr_addr_o = addr_q;
  assign wr_data_o = data_q;
  assign wr_strb_o = strb_q;
  assign b_valid_o = (state_q == S_RESP);
  assign b_id_o    = id_q;
  assign b_resp_o  = resp_q;

endmodule

//--- design/mem_bank.sv
`timescale 1ns/1ps

module mem_bank
  import axi_mem_pkg::*;
#(
  parameter int DEPTH_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              rd_req_i,
  input  logic [ADDR_W-4:0] rd_addr_i,
  output logic              rd_grant_o,
  output logic              rd_done_o,
  output logic [DATA_W-1:0] rd_data_o,
  output logic [1:0]        rd_resp_o,
  input  logic              wr_req_i,
  input  logic [ADDR_W-4:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic [STRB_W-1:0] wr_strb_i,
  output logic              wr_grant_o,
  output logic              wr_done_o,
  output logic [1:0]        wr_resp_o,
  output logic              uart_valid_o,
  output logic [7:0]        uart_data_o
);

  localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
  localparam logic [ADDR_W-4:0] SERIAL_WORD = SERIAL_ADDR[ADDR_W-1:3];
  localparam logic [ADDR_W-4:0] DEPTH_LIM   = (ADDR_W-3)'(DEPTH_WORDS);

  logic [DATA_W-1:0] mem_q [DEPTH_WORDS];

  logic              favor_rd_q;
  logic              rd_serial;
  logic              rd_hit;
  logic              wr_serial;
  logic              wr_hit;
  logic [IDX_W-1:0]  rd_idx;
  logic [IDX_W-1:0]  wr_idx;
  logic              rd_done_q;
  logic              wr_done_q;
  logic              uart_valid_q;
  logic [DATA_W-1:0] rd_data_q;
  logic [1:0]        rd_resp_q;
  logic [1:0]        wr_resp_q;
  logic [7:0]        uart_data_q;

  // round robin where the side not served last wins a tie
  assign rd_grant_o = rd_req_i && (!wr_req_i || favor_rd_q);
  assign wr_grant_o = wr_req_i && !rd_grant_o;

  // address decode on word index
  assign rd_serial = (rd_addr_i == SERIAL_WORD);
  assign wr_serial = (wr_addr_i == SERIAL_WORD);
  assign rd_hit    = (rd_addr_i < DEPTH_LIM) && !rd_serial;
  assign wr_hit    = (wr_addr_i < DEPTH_LIM) && !wr_serial;
  assign rd_idx    = rd_addr_i[IDX_W-1:0];
  assign wr_idx    = wr_addr_i[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      favor_rd_q   <= 1'b1;
      rd_done_q    <= 1'b0;
      wr_done_q    <= 1'b0;
      uart_valid_q <= 1'b0;
    end else begin
      rd_done_q    <= rd_grant_o;
      wr_done_q    <= wr_grant_o;
      uart_valid_q <= wr_grant_o && wr_serial;
      if (rd_grant_o) begin
        favor_rd_q <= 1'b0;
      end else if (wr_grant_o) begin
        favor_rd_q <= 1'b1;
      end
    end
  end

  // array access happens on the grant edge
  always_ff @(posedge clk) begin
    if (rd_grant_o) begin
      rd_data_q <= rd_hit ? mem_q[rd_idx] : '0;
      rd_resp_q <= (rd_hit || rd_serial) ? RESP_OKAY : RESP_SLVERR;
    end
    if (wr_grant_o) begin
      wr_resp_q   <= (wr_hit || wr_serial) ? RESP_OKAY : RESP_SLVERR;
      uart_data_q <= wr_data_i[7:0];
      if (wr_hit) begin
        // byte lane merge
        for (int b = 0; b < STRB_W; b++) begin
          if (wr_strb_i[b]) begin
            mem_q[wr_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
          end
        end
      end
    end
  end

  assign rd_done_o    = rd_done_q;
  assign rd_data_o    = rd_data_q;
  assign rd_resp_o    = rd_resp_q;
  assign wr_done_o    = wr_done_q;
  assign wr_resp_o    = wr_resp_q;
  assign uart_valid_o = uart_valid_q;
  assign uart_data_o  = uart_data_q;

endmodule

//--- design/stall_lfsr.sv
`timescale 1ns/1ps

module stall_lfsr #(
  parameter bit          STALL_EN   = 1'b1,
  parameter logic [19:0] STALL_SEED = 20'd101
) (
  input  logic clk,
  input  logic rst_i,
  output logic go_o
);

  logic [19:0] lfsr_q;

  // maximal length taps for x^20 + x^17 + 1
  always_ff @(posedge clk) begin
    if (rst_i) begin
      lfsr_q <= STALL_SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  // top bit gives roughly half the cycles as go
  assign go_o = STALL_EN ? lfsr_q[19] : 1'b1;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_axi_mem_uart \
  -f axi_mem_uart.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if grep -q "All checks passed" <<< "$out"; then
  exit 0
fi
exit 1

//--- test/axi_trace.txt
# op id addr data strb resp, all hex after op
# W writes data under strb, R expects data and resp (strb unused)
W 1 00000000 0123456789abcdef ff 0
R 2 00000000 0123456789abcdef 00 0
W 3 00000008 1122334455667788 ff 0
W 4 00000010 a5a5a5a5a5a5a5a5 ff 0
R 5 00000008 1122334455667788 00 0
R 6 00000010 a5a5a5a5a5a5a5a5 00 0
W 7 00000008 ffeeddccbbaa9988 0f 0
R 8 00000008 11223344bbaa9988 00 0
W 9 00000008 0000ff0000000000 20 0
R a 00000008 1122ff44bbaa9988 00 0
W b 000007f8 cafef00ddeadbeef ff 0
W c 000007f8 0000000000000000 81 0
R d 000007f8 00fef00ddeadbe00 00 0
W 1 a00003f8 0000000000000048 01 0
W 2 a00003f8 0000000000000069 01 0
W 3 a00003f8 123456789abcde21 ff 0
W 4 a00003f8 000000000000000a 01 0
R 5 a00003f8 0000000000000000 00 0
W 6 00000800 ffffffffffffffff ff 2
R 7 00000800 0000000000000000 00 2
W 8 10000000 5555555555555555 ff 2
R 9 10000000 0000000000000000 00 2
R a 00000000 0123456789abcdef 00 0
W b a00003f0 7777777777777777 ff 2
R c a00003f0 0000000000000000 00 2
R d 00000000 0123456789abcdef 00 0
R e 000007f8 00fef00ddeadbe00 00 0
R f 00000008 1122ff44bbaa9988 00 0

//--- test/tb_axi_mem_uart.sv
`timescale 1ns/1ps

module tb_axi_mem_uart
  import axi_mem_pkg::*;
;

  localparam int MAX_TXN = 64;

  logic              clk = 1'b0;
  logic              rst_i;
  logic              ar_valid_i;
  logic              ar_ready_o;
  logic [ID_W-1:0]   ar_id_i;
  logic [ADDR_W-1:0] ar_addr_i;
  logic              r_valid_o;
  logic              r_ready_i;
  logic [ID_W-1:0]   r_id_o;
  logic [DATA_W-1:0] r_data_o;
  logic [1:0]        r_resp_o;
  logic              aw_valid_i;
  logic              aw_ready_o;
  logic [ID_W-1:0]   aw_id_i;
  logic [ADDR_W-1:0] aw_addr_i;
  logic              w_valid_i;
  logic              w_ready_o;
  logic [DATA_W-1:0] w_data_i;
  logic [STRB_W-1:0] w_strb_i;
  logic              b_valid_o;
  logic              b_ready_i;
  logic [ID_W-1:0]   b_id_o;
  logic [1:0]        b_resp_o;
  logic              uart_valid_o;
  logic [7:0]        uart_data_o;

  // trace contents
  logic [7:0]        tr_op   [MAX_TXN];
  logic [ID_W-1:0]   tr_id   [MAX_TXN];
  logic [ADDR_W-1:0] tr_addr [MAX_TXN];
  logic [DATA_W-1:0] tr_data [MAX_TXN];
  logic [STRB_W-1:0] tr_strb [MAX_TXN];
  logic [1:0]        tr_resp [MAX_TXN];
  int                n_tr = 0;

  logic [7:0] exp_bytes [$];
  logic [7:0] exp_b;
  logic [31:0] rng = 32'd21;
  int n_checks = 0;
  int n_mismatch = 0;
  int n_other = 0;
  int cycles = 0;
  int limit = 0;
  logic loaded;

  axi_mem_uart axi_mem_uart_i (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    n_checks = n_checks + 1;
    if (act_v !== exp_v) begin
      n_mismatch = n_mismatch + 1;
      $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic report_error(input string msg);
    n_other = n_other + 1;
    $display("Error: %s", msg);
  endtask

  task automatic print_counts();
    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             n_checks, n_mismatch, n_other);
  endtask

  task automatic load_trace(output logic ok);
    int fd;
    int code;
    logic [7:0] op;
    logic [8*256-1:0] skip_buf;
    logic more;
    ok = 1'b0;
    fd = $fopen("test/axi_trace.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      more = 1'b1;
      while (more) begin
        code = $fscanf(fd, " %c", op);
        if (code != 1) begin
          more = 1'b0;
        end else if (op == "#") begin
          code = $fgets(skip_buf, fd);
        end else if (n_tr >= MAX_TXN) begin
          report_error($sformatf("trace holds more than %0d entries", MAX_TXN));
          more = 1'b0;
        end else begin
          code = $fscanf(fd, " %h %h %h %h %h", tr_id[n_tr], tr_addr[n_tr],
                         tr_data[n_tr], tr_strb[n_tr], tr_resp[n_tr]);
          if (code != 5) begin
            report_error($sformatf("trace entry %0d could not be parsed", n_tr));
            more = 1'b0;
          end else begin
            tr_op[n_tr] = op;
            n_tr = n_tr + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // response wait with hold checks while the master stalls
  task automatic wait_b(input int n, input string tag);
    logic seen;
    logic done;
    logic [ID_W-1:0] id_c;
    logic [1:0] resp_c;
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (b_valid_o) begin
        if (!seen) begin
          seen = 1'b1;
          id_c = b_id_o;
          resp_c = b_resp_o;
        end else begin
          check_val({tag, " hold b_id"}, 64'(id_c), 64'(b_id_o));
          check_val({tag, " hold b_resp"}, 64'(resp_c), 64'(b_resp_o));
        end
        if (b_ready_i) begin
          done = 1'b1;
          check_val({tag, " b_id"}, 64'(tr_id[n]), 64'(b_id_o));
          check_val({tag, " b_resp"}, 64'(tr_resp[n]), 64'(b_resp_o));
        end
      end else if (seen) begin
        report_error({tag, ": b_valid_o dropped before the transfer"});
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_r(input int n, input string tag);
    logic seen;
    logic done;
    logic [ID_W-1:0] id_c;
    logic [DATA_W-1:0] data_c;
    logic [1:0] resp_c;
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (r_valid_o) begin
        if (!seen) begin
          seen = 1'b1;
          id_c = r_id_o;
          data_c = r_data_o;
          resp_c = r_resp_o;
        end else begin
          check_val({tag, " hold r_id"}, 64'(id_c), 64'(r_id_o));
          check_val({tag, " hold r_data"}, data_c, r_data_o);
          check_val({tag, " hold r_resp"}, 64'(resp_c), 64'(r_resp_o));
        end
        if (r_ready_i) begin
          done = 1'b1;
          check_val({tag, " r_id"}, 64'(tr_id[n]), 64'(r_id_o));
          check_val({tag, " r_data"}, tr_data[n], r_data_o);
          check_val({tag, " r_resp"}, 64'(tr_resp[n]), 64'(r_resp_o));
        end
      end else if (seen) begin
        report_error({tag, ": r_valid_o dropped before the transfer"});
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_write(input int n);
    string tag;
    tag = $sformatf("txn %0d write", n);
    if (tr_addr[n] == SERIAL_ADDR) begin
      exp_bytes.push_back(tr_data[n][7:0]);
    end
    aw_valid_i = 1'b1;
    aw_id_i = tr_id[n];
    aw_addr_i = tr_addr[n];
    do @(negedge clk); while (!aw_ready_o);
    @(posedge clk);
    #1;
    aw_valid_i = 1'b0;
    w_valid_i = 1'b1;
    w_data_i = tr_data[n];
    w_strb_i = tr_strb[n];
    do @(negedge clk); while (!w_ready_o);
    @(posedge clk);
    #1;
    w_valid_i = 1'b0;
    wait_b(n, tag);
  endtask

  task automatic run_read(input int n);
    string tag;
    tag = $sformatf("txn %0d read", n);
    ar_valid_i = 1'b1;
    ar_id_i = tr_id[n];
    ar_addr_i = tr_addr[n];
    do @(negedge clk); while (!ar_ready_o);
    @(posedge clk);
    #1;
    ar_valid_i = 1'b0;
    wait_r(n, tag);
  endtask

  // random back-pressure on both response channels
  initial begin : ready_drive
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rng = xorshift32(rng);
      r_ready_i = rng[3];
      b_ready_i = rng[11];
    end
  end

  always @(negedge clk) begin
    if (!rst_i && uart_valid_o) begin
      if (exp_bytes.size() == 0) begin
        report_error("serial byte arrived while none was expected");
      end else begin
        exp_b = exp_bytes.pop_front();
        check_val("serial byte", 64'(exp_b), 64'(uart_data_o));
      end
    end
  end

  initial begin : watchdog
    @(posedge clk);
    while (limit == 0 || cycles < limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    report_error($sformatf("timeout with the trace unfinished after %0d cycles", limit));
    print_counts();
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_i = 1'b1;
    ar_valid_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    aw_valid_i = 1'b0;
    aw_id_i = '0;
    aw_addr_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    load_trace(loaded);
    if (!loaded) begin
      report_error("could not open the trace file test/axi_trace.txt");
    end else begin
      limit = n_tr * 200;
      repeat (5) @(posedge clk);
      #1;
      rst_i = 1'b0;
      @(negedge clk);
      check_val("reset ar_ready_o", 64'(0), 64'(ar_ready_o));
      check_val("reset aw_ready_o", 64'(0), 64'(aw_ready_o));
      check_val("reset w_ready_o", 64'(0), 64'(w_ready_o));
      check_val("reset r_valid_o", 64'(0), 64'(r_valid_o));
      check_val("reset b_valid_o", 64'(0), 64'(b_valid_o));
      check_val("reset uart_valid_o", 64'(0), 64'(uart_valid_o));
      @(posedge clk);
      #1;
      for (int i = 0; i < n_tr; i++) begin
        if (tr_op[i] == "W") begin
          run_write(i);
        end else begin
          run_read(i);
        end
      end
      repeat (3) @(posedge clk);
      if (exp_bytes.size() != 0) begin
        report_error($sformatf("%0d serial bytes expected but never seen", exp_bytes.size()));
      end
    end
    print_counts();
    if (n_mismatch == 0 && n_other == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
